// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_sampler
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: common/sampler_pkg.sv
// Shared widths, burst sizes, APB register map and DMA state type, imported by every voice block

package sampler_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W   = 32;           // DMA and APB address width
    localparam int DATA_W   = 32;           // DMA data and FIFO word width
    localparam int SAMPLE_W = 16;           // One output sample, two per word

    //////////////////////////////////////////////////////////////////////
    // DMA burst sizes
    //////////////////////////////////////////////////////////////////////
    localparam int INFO_BURST_LEN   = 4;    // Voice information table, in words
    localparam int STREAM_BURST_LEN = 64;   // One stream burst, in words
    localparam int STREAM_ADDR_INCR = 256;  // Byte step between stream bursts

    localparam int FIFO_DEPTH_DEFAULT = 128; // Two stream bursts of buffering

    //////////////////////////////////////////////////////////////////////
    // APB register offsets
    //////////////////////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] REG_CTRL   = 32'h0000_0000; // W: bit0 start, bit1 stop
    localparam logic [ADDR_W-1:0] REG_BASE   = 32'h0000_0004; // RW: info table address
    localparam logic [ADDR_W-1:0] REG_STATUS = 32'h0000_0008; // bit0 busy, bit1 underrun
    localparam logic [ADDR_W-1:0] REG_BURSTS = 32'h0000_000C; // RO: completed bursts

    // Voice DMA controller states
    typedef enum logic [2:0] {
        IDLE,           // Waiting for start
        INFO_REQ,       // Issue info table request
        INFO_WAIT,      // Collect the four table words
        STREAM_REQ,     // Wait for FIFO room, then request a burst
        STREAM_WAIT     // Burst data flowing into FIFO
    } voice_dma_state_e;

endpackage

// File: flist.f
common/sampler_pkg.sv
hdl/sampler_apb_regs.sv
voice_dma/voice_dma_fsm.sv
voice_dma/sample_fifo.sv
hdl/sample_out.sv
hdl/sampler_top.sv
test/tb_mem_model.sv
test/tb_sampler.sv

// File: hdl/sample_out.sv
// Output stage, splits FIFO words into 16-bit samples on each sample_tick and flags underrun
`timescale 1ns/1ps

module sample_out (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             sample_tick,
    input  logic [sampler_pkg::DATA_W-1:0]   rd_data,
    input  logic                             empty,
    output logic                             rd_en,
    output logic [sampler_pkg::SAMPLE_W-1:0] sample_data,
    output logic                             sample_valid,
    output logic                             underrun_pulse
);
    import sampler_pkg::*;

    logic half_sel;                     // 0 low half next, 1 high half next
    logic take;                         // Tick with a word available

    assign take  = sample_tick && !empty;
    assign rd_en = take && half_sel;    // Pop once the high half is out

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            half_sel       <= 1'b0;
            sample_valid   <= 1'b0;
            underrun_pulse <= 1'b0;
        end else begin
            sample_valid   <= take;
            underrun_pulse <= sample_tick && empty; // Tick found nothing
            if (take)
                half_sel <= !half_sel;
        end
    end

    // Sample register
    always_ff @(posedge clk) begin
        if (take)
            sample_data <= half_sel ? rd_data[DATA_W-1:SAMPLE_W] : rd_data[SAMPLE_W-1:0];
    end

endmodule

// File: hdl/sampler_apb_regs.sv
// APB slave for the voice channel, holds the table base, issues start/stop and reports status
`timescale 1ns/1ps

module sampler_apb_regs (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [sampler_pkg::ADDR_W-1:0] paddr,
    input  logic [sampler_pkg::DATA_W-1:0] pwdata,
    output logic [sampler_pkg::DATA_W-1:0] prdata,
    output logic                           start_voice,
    output logic                           stop_voice,
    output logic [sampler_pkg::ADDR_W-1:0] voice_base_addr,
    input  logic                           busy,
    input  logic                           burst_done,
    input  logic                           underrun_pulse
);
    import sampler_pkg::*;

    logic              wr_acc;          // Write in the access phase
    logic              underrun_sticky;
    logic [DATA_W-1:0] burst_cnt;       // Completed stream bursts

    assign wr_acc = psel && penable && pwrite;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_voice     <= 1'b0;
            stop_voice      <= 1'b0;
            voice_base_addr <= '0;
            underrun_sticky <= 1'b0;
            burst_cnt       <= '0;
        end else begin
            // Pulses land the cycle after the access phase
            start_voice <= wr_acc && (paddr == REG_CTRL) && pwdata[0];
            stop_voice  <= wr_acc && (paddr == REG_CTRL) && pwdata[1];
            if (wr_acc && (paddr == REG_BASE))
                voice_base_addr <= pwdata;
            if (underrun_pulse)
                underrun_sticky <= 1'b1;        // Set beats a clear in the same cycle
            else if (wr_acc && (paddr == REG_STATUS) && pwdata[1])
                underrun_sticky <= 1'b0;        // W1C
            if (start_voice)
                burst_cnt <= '0;                // New voice, new count
            else if (burst_done)
                burst_cnt <= burst_cnt + 1'b1;
        end
    end

    // Read mux, valid while the access phase is up
    always_comb begin
        case (paddr)
            REG_BASE:   prdata = voice_base_addr;
            REG_STATUS: prdata = {{(DATA_W-2){1'b0}}, underrun_sticky, busy};
            REG_BURSTS: prdata = burst_cnt;
            default:    prdata = '0;            // CTRL reads back zero
        endcase
    end

    // Access phase always follows a setup phase with psel held
    a_apb_phase: assert property (@(posedge clk) disable iff (!reset_n)
        penable |-> psel && $past(psel));

endmodule

// File: hdl/sampler_top.sv
// Top level of one voice channel, wires APB registers, voice DMA, FIFO and output stage
`timescale 1ns/1ps

module sampler_top (
    input  logic                             clk,
    input  logic                             reset_n,
    // APB
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [sampler_pkg::ADDR_W-1:0]   paddr,
    input  logic [sampler_pkg::DATA_W-1:0]   pwdata,
    output logic [sampler_pkg::DATA_W-1:0]   prdata,
    // DMA request and return
    output logic                             dma_req,
    output logic [sampler_pkg::ADDR_W-1:0]   dma_addr,
    output logic [7:0]                       dma_len,
    input  logic [sampler_pkg::DATA_W-1:0]   dma_data,
    input  logic                             dma_data_valid,
    input  logic                             dma_data_last,
    // Audio out
    input  logic                             sample_tick,
    output logic [sampler_pkg::SAMPLE_W-1:0] sample_data,
    output logic                             sample_valid
);
    import sampler_pkg::*;

    logic                                     start_voice;
    logic                                     stop_voice;
    logic [ADDR_W-1:0]                        voice_base_addr;
    logic                                     busy;
    logic                                     burst_done;
    logic                                     underrun_pulse;
    logic                                     fifo_wr_en;
    logic [DATA_W-1:0]                        fifo_wr_data;
    logic [$clog2(FIFO_DEPTH_DEFAULT+1)-1:0]  fill_count;
    logic                                     fifo_rd_en;
    logic [DATA_W-1:0]                        fifo_rd_data;
    logic                                     fifo_empty;

    sampler_apb_regs u_regs (
        .clk, .reset_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .start_voice, .stop_voice, .voice_base_addr,
        .busy, .burst_done, .underrun_pulse
    );

    voice_dma_fsm u_dma (
        .clk, .reset_n, .start_voice, .stop_voice, .voice_base_addr,
        .dma_req, .dma_addr, .dma_len, .dma_data, .dma_data_valid, .dma_data_last,
        .fifo_wr_en, .fifo_wr_data, .fill_count, .busy, .burst_done
    );

    sample_fifo u_fifo (
        .clk, .reset_n,
        .wr_en      (fifo_wr_en),
        .wr_data    (fifo_wr_data),
        .rd_en      (fifo_rd_en),
        .rd_data    (fifo_rd_data),
        .empty      (fifo_empty),
        .fill_count (fill_count)
    );

    sample_out u_out (
        .clk, .reset_n, .sample_tick,
        .rd_data        (fifo_rd_data),
        .empty          (fifo_empty),
        .rd_en          (fifo_rd_en),
        .sample_data, .sample_valid, .underrun_pulse
    );

endmodule

// File: test/tb_mem_model.sv
// System memory model for the voice DMA port, serves bursts with random latency and logs requests
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        dma_req,
    input  logic [31:0] dma_addr,
    input  logic [7:0]  dma_len,
    output logic [31:0] dma_data,
    output logic        dma_data_valid,
    output logic        dma_data_last
);
    localparam int MEM_WORDS = 1024;    // 4 KB of word storage

    logic [31:0] mem [MEM_WORDS];       // Testbench writes the info table here too
    logic [31:0] req_addr_q [$];        // Request log, one entry per dma_req
    logic [7:0]  req_len_q [$];
    integer      seed;

    //////////////////////////////////////////////////////////////////////
    // Fill and request service
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] addr;
        logic [7:0]  len;
        int          lat;
        int          widx;
        seed           = 35079;
        dma_data       = '0;
        dma_data_valid = 1'b0;
        dma_data_last  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);     // Every word its own random value
        end
        forever begin
            @(negedge clk);             // Request lines settled mid-cycle
            if (reset_n && dma_req) begin
                addr = dma_addr;
                len  = dma_len;
                req_addr_q.push_back(addr);
                req_len_q.push_back(len);
                lat  = 2 + (($random(seed) & 32'h7fff_ffff) % 8); // 2 to 9 cycles
                repeat (lat) @(posedge clk);
                for (int i = 0; i < int'(len); i++) begin
                    widx = ((addr >> 2) + i) % MEM_WORDS;
                    dma_data       <= mem[widx];
                    dma_data_valid <= 1'b1;
                    dma_data_last  <= (i == int'(len) - 1); // Marks burst end
                    @(posedge clk);
                end
                dma_data_valid <= 1'b0;
                dma_data_last  <= 1'b0;
            end
        end
    end

endmodule

// File: test/tb_sampler.sv
// Testbench top for the voice channel, drives APB and ticks and checks samples against memory
`timescale 1ns/1ps

module tb_sampler;
    import sampler_pkg::*;

    // Three playing tests of about 4100 cycles each (512 samples x 8) plus margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] INFO_BASE = 32'h0000_0100;
    localparam logic [31:0] STREAM_START = 32'h0000_0400;
    localparam int N_BURSTS = 4;

    logic        clk;
    logic        reset_n;
    logic        psel, penable, pwrite;
    logic [31:0] paddr, pwdata, prdata;
    logic        dma_req;
    logic [31:0] dma_addr;
    logic [7:0]  dma_len;
    logic [31:0] dma_data;
    logic        dma_data_valid, dma_data_last;
    logic        sample_tick;
    logic [15:0] sample_data;
    logic        sample_valid;

    int          sample_cnt = 0;        // Samples seen in the current test
    int          sample_limit = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    logic        tick_en = 1'b0;
    logic [2:0]  tick_div = '0;

    sampler_top dut0 (.*);

    tb_mem_model mem0 (
        .clk, .reset_n, .dma_req, .dma_addr, .dma_len,
        .dma_data, .dma_data_valid, .dma_data_last
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    // One tick every 8 cycles while enabled
    always @(posedge clk) begin
        tick_div    <= tick_div + 3'd1;
        sample_tick <= tick_en && (tick_div == 3'd7);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and sample compare
    //////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] expected_sample(input int n);
        logic [31:0] word;
        word = mem0.mem[((STREAM_START >> 2) + n / 2) % 1024];
        return (n % 2 == 0) ? word[15:0] : word[31:16]; // Low half first
    endfunction

    always @(negedge clk) begin
        if (reset_n && sample_valid) begin
            assert (sample_cnt < sample_limit) else begin
                $display("Error at %0t: sample_valid with no sample left in the stream", $time);
                err_cnt++;
            end
            assert (sample_data == expected_sample(sample_cnt)) else begin
                $display("Mismatch at %0t: sample_data = %h, expected %h (sample %0d)",
                         $time, sample_data, expected_sample(sample_cnt), sample_cnt);
                err_cnt++;
            end
            sample_cnt++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB access and check helpers
    //////////////////////////////////////////////////////////////////////
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;                // Setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;                // Access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;                  // Valid during access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("Test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h1;
        while (st[0]) apb_read(REG_STATUS, st);   // Poll busy
    endtask

    task automatic wait_requests(input int n);
        while (mem0.req_addr_q.size() < n) @(posedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        int          errs;
        int          base;
        int          n_req;
        int          cnt_at;
        reset_n     = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sample_tick = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        mem0.mem[INFO_BASE >> 2]       = STREAM_START;     // Word 0 start address
        mem0.mem[(INFO_BASE >> 2) + 1] = N_BURSTS;         // Word 1 length in bursts

        // Reset values and BASE read-back
        errs = err_cnt;
        apb_read(REG_STATUS, rd);
        check_val("STATUS", rd, 32'h0);
        apb_read(REG_BURSTS, rd);
        check_val("BURSTS", rd, 32'h0);
        apb_write(REG_BASE, 32'hA5C3_1E70);
        apb_read(REG_BASE, rd);
        check_val("BASE", rd, 32'hA5C3_1E70);
        report_test("1 reset and BASE", errs);

        // Full playback of a 4-burst stream
        errs = err_cnt;
        sample_cnt   = 0;
        sample_limit = N_BURSTS * STREAM_BURST_LEN * 2;
        apb_write(REG_BASE, INFO_BASE);
        apb_write(REG_CTRL, 32'h1);
        wait_requests(3);               // First burst fully in the FIFO
        tick_en <= 1'b1;
        while (sample_cnt < sample_limit) @(posedge clk);
        wait_idle();
        repeat (160) @(posedge clk);    // Twenty more ticks, nothing left to play
        check_val("sample count", sample_cnt, sample_limit);
        tick_en <= 1'b0;
        apb_read(REG_BURSTS, rd);
        check_val("BURSTS", rd, N_BURSTS);
        report_test("2 full playback", errs);

        // DMA request log of that playback
        errs = err_cnt;
        check_val("request count", mem0.req_addr_q.size(), 1 + N_BURSTS);
        check_val("req 0 addr", mem0.req_addr_q[0], INFO_BASE);
        check_val("req 0 len", mem0.req_len_q[0], INFO_BURST_LEN);
        for (int k = 0; k < N_BURSTS; k++) begin
            check_val("stream req addr", mem0.req_addr_q[k + 1],
                      STREAM_START + k * STREAM_ADDR_INCR);
            check_val("stream req len", mem0.req_len_q[k + 1], STREAM_BURST_LEN);
        end
        report_test("3 request log", errs);

        // Stop in the middle of a stream
        errs = err_cnt;
        apb_write(REG_STATUS, 32'h2);   // Clear underrun left by the drain
        base       = mem0.req_addr_q.size();
        sample_cnt = 0;
        apb_write(REG_CTRL, 32'h1);
        wait_requests(base + 3);
        tick_en <= 1'b1;
        wait_requests(base + 4);        // Third stream burst on its way
        apb_write(REG_CTRL, 32'h2);
        wait_idle();
        n_req = mem0.req_addr_q.size();
        repeat (300) @(posedge clk);
        check_val("requests after stop", mem0.req_addr_q.size(), n_req);
        assert (n_req < base + 1 + N_BURSTS) else begin
            $display("Error at %0t: stream ran to its end despite the stop", $time);
            err_cnt++;
        end
        report_test("4 stop", errs);

        // Underrun once the FIFO drains
        errs = err_cnt;
        rd = '0;
        while (!rd[1]) apb_read(REG_STATUS, rd);  // Ticks keep draining
        cnt_at = sample_cnt;
        repeat (80) @(posedge clk);
        check_val("sample count after drain", sample_cnt, cnt_at);
        tick_en <= 1'b0;
        repeat (16) @(posedge clk);
        apb_read(REG_STATUS, rd);
        check_val("STATUS", rd, 32'h2);
        apb_write(REG_STATUS, 32'h2);
        apb_read(REG_STATUS, rd);
        check_val("STATUS", rd, 32'h0);
        report_test("5 underrun", errs);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: voice_dma/sample_fifo.sv
// Show-ahead word FIFO between the voice DMA and the sample output, with a fill count
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DEPTH = sampler_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           wr_en,
    input  logic [sampler_pkg::DATA_W-1:0] wr_data,
    input  logic                           rd_en,
    output logic [sampler_pkg::DATA_W-1:0] rd_data,
    output logic                           empty,
    output logic [$clog2(DEPTH+1)-1:0]     fill_count
);
    import sampler_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    assign rd_data = mem[rd_ptr];       // Head word visible before the pop
    assign empty   = fill_count == '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en |-> fill_count < DEPTH);
    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        rd_en |-> !empty);

endmodule

// File: voice_dma/voice_dma_fsm.sv
// Voice DMA controller, fetches the info table then streams bursts into the sample FIFO
`timescale 1ns/1ps

module voice_dma_fsm (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           start_voice,
    input  logic                           stop_voice,
    input  logic [sampler_pkg::ADDR_W-1:0] voice_base_addr,
    output logic                           dma_req,
    output logic [sampler_pkg::ADDR_W-1:0] dma_addr,
    output logic [7:0]                     dma_len,
    input  logic [sampler_pkg::DATA_W-1:0] dma_data,
    input  logic                           dma_data_valid,
    input  logic                           dma_data_last,
    output logic                           fifo_wr_en,
    output logic [sampler_pkg::DATA_W-1:0] fifo_wr_data,
    input  logic [$clog2(sampler_pkg::FIFO_DEPTH_DEFAULT+1)-1:0] fill_count,
    output logic                           busy,
    output logic                           burst_done
);
    import sampler_pkg::*;

    voice_dma_state_e  state;
    voice_dma_state_e  state_next;
    logic [1:0]        info_cnt;        // Word index inside the info table
    logic [DATA_W-1:0] info_start;      // Table word 0
    logic [DATA_W-1:0] info_len;        // Table word 1, in bursts
    logic [ADDR_W-1:0] stream_addr;     // Address of the next stream burst
    logic [DATA_W-1:0] stream_len;
    logic [DATA_W-1:0] bursts_done;
    logic              stop_pending;    // Stop seen while a burst was in flight
    logic              req_open;        // A request is outstanding
    logic              burst_end;
    logic              room;
    logic              last_burst;

    assign burst_end  = dma_data_valid && dma_data_last;
    assign room       = fill_count <= (FIFO_DEPTH_DEFAULT - STREAM_BURST_LEN); // Whole burst fits
    assign last_burst = (bursts_done + 1'b1) == stream_len;

    //////////////////////////////////////////////////////////////////////
    // State transitions
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_voice)
                    state_next = INFO_REQ;
            end
            INFO_REQ: begin
                state_next = stop_voice ? IDLE : INFO_WAIT; // Request goes out here
            end
            INFO_WAIT: begin
                if (burst_end) begin
                    if (stop_pending || stop_voice || (info_len == '0))
                        state_next = IDLE;      // Stopped or empty stream
                    else
                        state_next = STREAM_REQ;
                end
            end
            STREAM_REQ: begin
                if (stop_voice)
                    state_next = IDLE;
                else if (room)
                    state_next = STREAM_WAIT;
            end
            STREAM_WAIT: begin
                if (burst_end) begin
                    if (stop_pending || stop_voice || last_burst)
                        state_next = IDLE;
                    else
                        state_next = STREAM_REQ;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Request outputs straight from the state
    assign dma_req  = !stop_voice && ((state == INFO_REQ) || ((state == STREAM_REQ) && room));
    assign dma_addr = (state == INFO_REQ) ? voice_base_addr : stream_addr;
    assign dma_len  = (state == INFO_REQ) ? 8'(INFO_BURST_LEN) : 8'(STREAM_BURST_LEN);

    assign fifo_wr_en   = (state == STREAM_WAIT) && dma_data_valid; // Same cycle as arrival
    assign fifo_wr_data = dma_data;
    assign busy         = state != IDLE;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            info_cnt     <= '0;
            stream_addr  <= '0;
            stream_len   <= '0;
            bursts_done  <= '0;
            stop_pending <= 1'b0;
            req_open     <= 1'b0;
            burst_done   <= 1'b0;
        end else begin
            state      <= state_next;
            burst_done <= (state == STREAM_WAIT) && burst_end;

            if (state == INFO_REQ)
                info_cnt <= '0;
            else if ((state == INFO_WAIT) && dma_data_valid)
                info_cnt <= info_cnt + 2'd1;

            // Stops in a wait state are held until the burst drains
            if (state_next == IDLE)
                stop_pending <= 1'b0;
            else if (stop_voice && ((state == INFO_WAIT) || (state == STREAM_WAIT)))
                stop_pending <= 1'b1;

            if (dma_req)
                req_open <= 1'b1;
            else if (burst_end)
                req_open <= 1'b0;

            if ((state == INFO_WAIT) && burst_end) begin
                stream_addr <= info_start;      // Table complete, load stream
                stream_len  <= info_len;
                bursts_done <= '0;
            end else if ((state == STREAM_WAIT) && burst_end) begin
                stream_addr <= stream_addr + STREAM_ADDR_INCR;
                bursts_done <= bursts_done + 1'b1;
            end
        end
    end

    // Table capture, words 2 and 3 are reserved
    always_ff @(posedge clk) begin
        if ((state == INFO_WAIT) && dma_data_valid) begin
            if (info_cnt == 2'd0)
                info_start <= dma_data;
            if (info_cnt == 2'd1)
                info_len <= dma_data;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
        dma_req |-> !req_open);
    a_fifo_room: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_wr_en |-> fill_count < FIFO_DEPTH_DEFAULT);

endmodule
